/* filelist.f */
+incdir+include
verilog/noc_flit_pkg.sv
verilog/core_msg_pkg.sv
verilog/flit_serializer.sv
verilog/flit_fifo.sv
verilog/flit_deserializer.sv
verilog/noc_link.sv
test/noc_link_tb.sv

/* include/noc_params.svh */
`ifndef NOC_PARAMS_SVH
`define NOC_PARAMS_SVH

////////////////////////////////////////////////////////////////////////////
// router flit geometry
////////////////////////////////////////////////////////////////////////////

`define NOC_FLIT_W      11  // tail bit plus data field
`define NOC_FLIT_DATA_W 10  // data field of a data flit

////////////////////////////////////////////////////////////////////////////
// core word fields, top bit down
////////////////////////////////////////////////////////////////////////////

`define NOC_ROUTE_W     5   // destination route
`define NOC_CODE_W      7   // opcode, sent in one data flit
`define NOC_PAYLOAD_W   20  // payload, sent as two data flits

////////////////////////////////////////////////////////////////////////////
// link buffering
////////////////////////////////////////////////////////////////////////////

// entries in the flit fifo, keep it a power of two
`define NOC_FIFO_DEPTH  8

`endif

/* test/noc_link_tb.sv */
`timescale 1ns/1ps
`include "noc_params.svh"

module noc_link_tb;

	localparam int n_entries   = 12;
	localparam int ack_timeout = 500; // cycles to wait for tx_a
	localparam int rx_timeout  = 500; // cycles to wait for rx_v

	// one table row holds a word to send and how long the receiver sits on it
	typedef struct packed {
		core_msg_pkg::core_tx_t tx;
		logic [7:0]             stall;
	} stim_t;

	logic                    clk;
	logic                    reset;
	logic                    tx_v;
	core_msg_pkg::core_tx_t  tx_d;
	logic                    tx_a;
	logic                    rx_v;
	core_msg_pkg::core_msg_t rx_d;
	logic                    rx_a;

	stim_t                   stim_table [n_entries];
	core_msg_pkg::core_msg_t exp_q [$];  // built from the table by the route rule
	int                      mismatches;
	int                      timeouts;
	int                      words_seen; // transfers on rx
	int                      max_ack_wait;
	logic                    saw_full;
	logic                    abort;
	integer                  seed = 1;

	noc_link noc_link_i (
		.clk   (clk),
		.reset (reset),
		.tx_v  (tx_v),
		.tx_d  (tx_d),
		.tx_a  (tx_a),
		.rx_v  (rx_v),
		.rx_d  (rx_d),
		.rx_a  (rx_a)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk; // 40 ns period
	end

	////////////////////////////////////////////////////////////////////////////
	// compare tasks
	////////////////////////////////////////////////////////////////////////////

	task automatic check_msg(input core_msg_pkg::core_msg_t got,
	                         input core_msg_pkg::core_msg_t exp);
		if (got !== exp) begin
			$display("MISMATCH at %0d ns: rx_d got %h expected %h", $time, got, exp);
			mismatches++;
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("MISMATCH at %0d ns: %s got %0d expected %0d", $time, name, got, exp);
			mismatches++;
		end
	endtask

	task automatic check_level(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("MISMATCH at %0d ns: %s got %b expected %b", $time, name, got, exp);
			mismatches++;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// stimulus table
	////////////////////////////////////////////////////////////////////////////

	task automatic set_entry(input int idx, input logic [4:0] route, input logic [6:0] code,
	                         input logic [19:0] payload, input logic last, input int stall);
		stim_table[idx].tx.msg.route   = route;
		stim_table[idx].tx.msg.code    = code;
		stim_table[idx].tx.msg.payload = payload;
		stim_table[idx].tx.last        = last;
		stim_table[idx].stall          = stall[7:0];
	endtask

	task automatic fill_table;
		// single word packets with field placement patterns
		set_entry(0, 5'h1f, 7'h7f, 20'hfffff, 1'b1, 0);  // all ones
		set_entry(1, 5'h00, 7'h00, 20'h00000, 1'b1, 1);  // all zeros
		set_entry(2, 5'h15, 7'h2a, 20'haaaaa, 1'b1, 2);  // alternating
		set_entry(3, 5'h0a, 7'h55, 20'h55555, 1'b1, 0);
		// four word packet whose later routes must be dropped
		set_entry(4, 5'h03, 7'h11, 20'h12345, 1'b0, 40); // long stall fills the fifo
		set_entry(5, 5'h1c, 7'h22, 20'h6789a, 1'b0, 30);
		set_entry(6, 5'h11, 7'h33, 20'hbcdef, 1'b0, 0);
		set_entry(7, 5'h08, 7'h44, 20'h0f0f0, 1'b1, 3);
		// single right behind the multi word packet
		set_entry(8, 5'h12, 7'h5a, 20'hc3c3c, 1'b1, 0);
		set_entry(9, 5'h07, 7'h66, 20'h80001, 1'b0, 25);
		set_entry(10, 5'h19, 7'h01, 20'h7fffe, 1'b1, 0);
		set_entry(11, 5'h0e, 7'h40, 20'h00400, 1'b1, 1);
	endtask

	// route of a packet comes from its first word only
	task automatic build_expected;
		logic [`NOC_ROUTE_W-1:0] pkt_route;
		logic                    first;
		core_msg_pkg::core_msg_t m;
		first     = 1'b1;
		pkt_route = '0;
		for (int i = 0; i < n_entries; i++) begin
			if (first)
				pkt_route = stim_table[i].tx.msg.route;
			m       = stim_table[i].tx.msg;
			m.route = pkt_route;
			exp_q.push_back(m);
			first   = stim_table[i].tx.last; // a last word opens the next packet
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// sending and receiving cores
	////////////////////////////////////////////////////////////////////////////

	task automatic send_words;
		int   waited;
		logic got;
		for (int i = 0; i < n_entries; i++) begin
			@(posedge clk);
			#2;
			tx_d   = stim_table[i].tx;
			tx_v   = 1'b1;
			waited = 0;
			got    = 1'b0;
			while (!got && waited < ack_timeout) begin
				@(negedge clk); // tx_a comes from a register and is stable here
				if (tx_a)
					got = 1'b1;
				else
					waited++;
			end
			if (!got) begin
				$display("timeout: word %0d was never acknowledged on tx_a", i);
				timeouts++;
				abort = 1'b1;
				break;
			end
			if (waited > max_ack_wait)
				max_ack_wait = waited;
		end
		@(posedge clk);
		#2 tx_v = 1'b0;
	endtask

	task automatic receive_words;
		int   waited;
		int   stall;
		for (int i = 0; i < n_entries; i++) begin
			waited = 0;
			while (!rx_v && waited < rx_timeout && !abort) begin
				@(negedge clk);
				waited++;
			end
			if (!rx_v) begin
				$display("timeout: word %0d never showed up on rx_v", i);
				timeouts++;
				abort = 1'b1;
				break;
			end
			check_msg(rx_d, exp_q[i]);
			stall = stim_table[i].stall + ($random(seed) & 3); // small random extra
			repeat (stall) @(posedge clk);
			@(posedge clk);
			#2 rx_a = 1'b1;
			@(negedge clk);
			check_level("rx_v", rx_v, 1'b1);  // still offered at the transfer
			check_msg(rx_d, exp_q[i]);         // and unchanged through the stall
			@(posedge clk);
			#2 rx_a = 1'b0;
			@(negedge clk);
		end
	endtask

	// transfer counter and fifo full watch
	always @(negedge clk) begin
		if (!reset && rx_v && rx_a)
			words_seen++;
		if (!reset && noc_link_i.full)
			saw_full = 1'b1;
	end

	////////////////////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		reset        = 1'b1;
		tx_v         = 1'b0;
		tx_d         = '0;
		rx_a         = 1'b0;
		mismatches   = 0;
		timeouts     = 0;
		words_seen   = 0;
		max_ack_wait = 0;
		saw_full     = 1'b0;
		abort        = 1'b0;

		fill_table();
		build_expected();

		repeat (5) @(posedge clk);
		#2 reset = 1'b0;

		// idle levels before any word goes in
		@(negedge clk);
		check_level("tx_a", tx_a, 1'b0);
		check_level("rx_v", rx_v, 1'b0);

		fork
			send_words();
			receive_words();
		join

		// nothing extra may come out after the table is done
		repeat (20) @(negedge clk);
		check_level("rx_v", rx_v, 1'b0);
		check_count("words received", words_seen, n_entries);
		check_level("fifo full", saw_full, 1'b1);
		check_level("tx_a withheld", max_ack_wait > 10, 1'b1); // serializer held back

		$display("%0d mismatches, %0d timeouts", mismatches, timeouts);
		if (mismatches == 0 && timeouts == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

/* verilog/core_msg_pkg.sv */
`include "noc_params.svh"

// core side word formats
package core_msg_pkg;

	////////////////////////////////////////////////////////////////////////////
	// core word
	//   [ route | code | payload ]
	//       5      7       20
	////////////////////////////////////////////////////////////////////////////
	typedef struct packed {
		logic [`NOC_ROUTE_W-1:0]   route;   // only the first word's route is sent
		logic [`NOC_CODE_W-1:0]    code;
		logic [`NOC_PAYLOAD_W-1:0] payload;
	} core_msg_t;

	////////////////////////////////////////////////////////////////////////////
	// transmit side word, core word plus packet end marker
	////////////////////////////////////////////////////////////////////////////
	typedef struct packed {
		core_msg_t msg;
		logic      last; // closes the packet, becomes the tail bit
	} core_tx_t;

	// receive side carries no marker, the deserializer tracks packets
	// from the tail bits itself

endpackage

/* verilog/flit_deserializer.sv */
`timescale 1ns/1ps
`include "noc_params.svh"

////////////////////////////////////////////////////////////////////////////
// router flits back to core words
//
// packet on the wire
//   header, then code / payload hi / payload lo per core word
//   tail set on the last flit of the packet
//
// core word out
//   [ route | code | payload ]
//       5      7       20
////////////////////////////////////////////////////////////////////////////

module flit_deserializer (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   empty,   // fifo has nothing to show
	input  noc_flit_pkg::flit_u    rd_flit, // head flit, show-ahead
	output logic                   rdreq,
	output logic                   rx_v,
	output core_msg_pkg::core_msg_t rx_d,
	input  logic                   rx_a
);

	typedef enum logic [2:0] {
		s_head,   // waiting for a header
		s_code,
		s_pay_hi,
		s_pay_lo,
		s_offer   // word complete, held for the core
	} des_state_e;

	des_state_e              state, next_state;
	core_msg_pkg::core_msg_t asm_word;  // assembly register
	logic                    tail_q;    // word ended the packet
	logic                    pop;
	logic                    flit_tail;

	// no popping while a word sits on rx
	assign rdreq     = !empty && (state != s_offer);
	assign pop       = rdreq;
	assign flit_tail = rd_flit.dat.tail; // only meaningful in data states

	////////////////////////////////////////////////////////////////////////////
	// fsm
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		next_state = state;
		case (state)
			s_head:   if (pop) next_state = s_code;
			s_code:   if (pop) next_state = flit_tail ? s_offer : s_pay_hi; // short word
			s_pay_hi: if (pop) next_state = flit_tail ? s_offer : s_pay_lo;
			s_pay_lo: if (pop) next_state = s_offer;
			s_offer:  if (rx_a) next_state = tail_q ? s_head : s_code; // route kept on s_code
			default:  next_state = s_head;
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state  <= s_head;
			tail_q <= 1'b1;
		end else begin
			state <= next_state;
			if (pop && state != s_head)
				tail_q <= flit_tail; // last data flit popped decides the return state
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// word assembly, loads only on a pop so rx_d holds while offered
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (pop) begin
			case (state)
				s_head: asm_word.route <= rd_flit.hdr.route; // header view
				s_code: begin
					asm_word.code    <= rd_flit.dat.data[`NOC_CODE_W-1:0];
					asm_word.payload <= '0; // a short word leaves no stale payload
				end
				s_pay_hi:
					asm_word.payload[`NOC_PAYLOAD_W-1 -: `NOC_FLIT_DATA_W] <= rd_flit.dat.data;
				s_pay_lo:
					asm_word.payload[`NOC_FLIT_DATA_W-1:0] <= rd_flit.dat.data;
				default: asm_word <= asm_word;
			endcase
		end
	end

	// offer
	assign rx_v = (state == s_offer); // drops the cycle after rx_a
	assign rx_d = asm_word;

endmodule

/* verilog/flit_fifo.sv */
`timescale 1ns/1ps
`include "noc_params.svh"

// show-ahead flit fifo, head flit is on rd_flit whenever empty is low
module flit_fifo (
	input  logic                clk,
	input  logic                reset,
	input  logic                wrreq,
	input  noc_flit_pkg::flit_u wr_flit,
	output logic                full,
	input  logic                rdreq,
	output noc_flit_pkg::flit_u rd_flit,
	output logic                empty
);

	localparam int addr_w = $clog2(`NOC_FIFO_DEPTH);

	noc_flit_pkg::flit_u mem [`NOC_FIFO_DEPTH]; // storage, no reset
	logic [addr_w:0]     wptr, rptr;            // extra msb tells wrap
	logic [addr_w:0]     wptr_n, rptr_n;
	logic                do_wr, do_rd;

	// a request past a limit is dropped here
	assign do_wr = wrreq && !full;
	assign do_rd = rdreq && !empty;

	assign wptr_n = wptr + {{addr_w{1'b0}}, do_wr};
	assign rptr_n = rptr + {{addr_w{1'b0}}, do_rd};

	////////////////////////////////////////////////////////////////////////////
	// pointers and levels
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			wptr  <= '0;
			rptr  <= '0;
			full  <= 1'b0;
			empty <= 1'b1;
		end else begin
			wptr  <= wptr_n;
			rptr  <= rptr_n;
			// levels from the next pointers so they line up with the data
			empty <= (wptr_n == rptr_n);
			full  <= (wptr_n[addr_w] != rptr_n[addr_w]) &&
			         (wptr_n[addr_w-1:0] == rptr_n[addr_w-1:0]); // wrapped once
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// storage
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wptr[addr_w-1:0]] <= wr_flit;
	end

	// head of queue, visible the cycle after it was written
	assign rd_flit = mem[rptr[addr_w-1:0]];

endmodule

/* verilog/flit_serializer.sv */
`timescale 1ns/1ps
`include "noc_params.svh"

// core words in, router flits out to the fifo
module flit_serializer (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    tx_v,    // core has a word
	input  core_msg_pkg::core_tx_t  tx_d,
	output logic                    tx_a,    // one cycle take pulse
	input  logic                    full,    // fifo cannot take a flit
	output logic                    wrreq,
	output noc_flit_pkg::flit_u     wr_flit
);

	typedef enum logic [2:0] {
		s_idle,   // waiting for a core word
		s_head,   // header flit, first word of a packet only
		s_code,
		s_pay_hi,
		s_pay_lo  // carries tail when the word closes the packet
	} ser_state_e;

	ser_state_e                 state, next_state;
	core_msg_pkg::core_tx_t     word;     // latched core word
	logic                       pkt_open; // header still owed
	noc_flit_pkg::flit_kind_e   kind;     // flit mux select
	noc_flit_pkg::flit_header_t hdr_view;
	noc_flit_pkg::flit_data_t   dat_view;

	////////////////////////////////////////////////////////////////////////////
	// fsm, every flit state holds while the fifo is full
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		next_state = state;
		case (state)
			s_idle:   if (tx_v) next_state = pkt_open ? s_head : s_code;
			s_head:   if (!full) next_state = s_code;
			s_code:   if (!full) next_state = s_pay_hi;
			s_pay_hi: if (!full) next_state = s_pay_lo;
			s_pay_lo: if (!full) next_state = s_idle;
			default:  next_state = s_idle;
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state    <= s_idle;
			tx_a     <= 1'b0;
			pkt_open <= 1'b1; // first word after reset starts a packet
		end else begin
			state <= next_state;
			tx_a  <= (state == s_idle) && tx_v; // ack the cycle after the word is seen
			if (state == s_head && !full)
				pkt_open <= 1'b0; // header is out, later words go straight to code
			else if (state == s_pay_lo && !full && word.last)
				pkt_open <= 1'b1; // packet closed, next word needs a header
		end
	end

	// word is latched on the same edge that schedules tx_a
	always_ff @(posedge clk) begin
		if (state == s_idle && tx_v)
			word <= tx_d;
	end

	////////////////////////////////////////////////////////////////////////////
	// flit build
	////////////////////////////////////////////////////////////////////////////

	assign wrreq = (state != s_idle) && !full; // one flit per free cycle
	assign kind  = (state == s_head) ? noc_flit_pkg::kind_header : noc_flit_pkg::kind_data;

	always_comb begin
		hdr_view       = '0;               // tail and pad stay low
		hdr_view.route = word.msg.route;
		dat_view       = '0;
		case (state)
			s_code:   dat_view.data = {{(`NOC_FLIT_DATA_W-`NOC_CODE_W){1'b0}}, word.msg.code};
			s_pay_hi: dat_view.data = word.msg.payload[`NOC_PAYLOAD_W-1 -: `NOC_FLIT_DATA_W];
			s_pay_lo: begin
				dat_view.data = word.msg.payload[`NOC_FLIT_DATA_W-1:0];
				dat_view.tail = word.last; // last flit of the packet
			end
			default:  dat_view = '0;
		endcase
	end

	// put the chosen view on the flit word
	always_comb begin
		if (kind == noc_flit_pkg::kind_header)
			wr_flit.hdr = hdr_view;
		else
			wr_flit.dat = dat_view;
	end

endmodule

/* verilog/noc_flit_pkg.sv */
`include "noc_params.svh"

// router side flit formats
package noc_flit_pkg;

	// header flit, first flit of every packet
	//   [ tail | pad | route ]
	//      1      5     5
	typedef struct packed {
		logic                                 tail;  // never set on a header
		logic [`NOC_FLIT_W-`NOC_ROUTE_W-2:0] pad;   // always zero
		logic [`NOC_ROUTE_W-1:0]             route; // where the packet goes
	} flit_header_t;

	// data flit, carries a code or payload slice
	//   [ tail | data ]
	//      1     10
	typedef struct packed {
		logic                        tail; // last flit of the packet
		logic [`NOC_FLIT_DATA_W-1:0] data;
	} flit_data_t;

	// one flit word, read as header or as data depending on fsm state
	typedef union packed {
		flit_header_t hdr;
		flit_data_t   dat;
	} flit_u;

	// which view the serializer puts on the wire
	typedef enum logic {
		kind_header = 1'b0,
		kind_data   = 1'b1
	} flit_kind_e;

endpackage

/* verilog/noc_link.sv */
`timescale 1ns/1ps

////////////////////////////////////////////////////////////////////////////
// one link between two cores
//   serializer -> flit fifo -> deserializer
////////////////////////////////////////////////////////////////////////////

module noc_link (
	input  logic                    clk,
	input  logic                    reset,
	// sending core
	input  logic                    tx_v,
	input  core_msg_pkg::core_tx_t  tx_d,
	output logic                    tx_a,
	// receiving core
	output logic                    rx_v,
	output core_msg_pkg::core_msg_t rx_d,
	input  logic                    rx_a
);

	// serializer to fifo
	logic                wrreq;
	logic                full;
	noc_flit_pkg::flit_u wr_flit;

	// fifo to deserializer
	logic                rdreq;
	logic                empty;
	noc_flit_pkg::flit_u rd_flit;

	flit_serializer ser_i (
		.clk     (clk),
		.reset   (reset),
		.tx_v    (tx_v),
		.tx_d    (tx_d),
		.tx_a    (tx_a),
		.full    (full),    // back-pressure from the fifo
		.wrreq   (wrreq),
		.wr_flit (wr_flit)
	);

	flit_fifo fifo_i (
		.clk     (clk),
		.reset   (reset),
		.wrreq   (wrreq),
		.wr_flit (wr_flit),
		.full    (full),
		.rdreq   (rdreq),
		.rd_flit (rd_flit),
		.empty   (empty)
	);

	flit_deserializer deser_i (
		.clk     (clk),
		.reset   (reset),
		.empty   (empty),
		.rd_flit (rd_flit),
		.rdreq   (rdreq),   // stops while rx is stalled
		.rx_v    (rx_v),
		.rx_d    (rx_d),
		.rx_a    (rx_a)
	);

endmodule
